// File: hdl/vlsu_params.svh
`ifndef VLSU_PARAMS_SVH
`define VLSU_PARAMS_SVH

// Element and memory word width in bits
`define VLSU_ELEN 32
// Bytes per word
`define VLSU_ELENB 4

// Register file geometry, in words per register and registers
`define VLSU_VREG_WORDS 8
`define VLSU_NR_VREGS 32

// Byte-count vector length, at most one full register of 32 bytes
`define VLSU_VL_W 6

// Reorder buffer entries and the ID that names one of them
`define VLSU_ROB_DEPTH 4
`define VLSU_ID_W 2

`endif

// File: hdl/vlsu_pkg.sv
package vlsu_pkg;

  `include "vlsu_params.svh"

  typedef enum logic [1:0] {
    VLE  = 2'd0,
    VSE  = 2'd1,
    VLSE = 2'd2,
    VSSE = 2'd3
  } vlsu_op_e;

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  typedef logic [`VLSU_ELEN-1:0] elen_t;
  typedef logic [`VLSU_ID_W-1:0] rob_id_t;
  typedef logic [$clog2(`VLSU_NR_VREGS*`VLSU_VREG_WORDS)-1:0] vrf_addr_t;

  // Vector memory instruction
  typedef struct packed {
    vlsu_op_e                          op;
    vsew_e                             vsew;
    // Element count on the request, byte count once registered
    logic [`VLSU_VL_W-1:0]             vl;
    logic [31:0]                       rs1;
    logic [31:0]                       rs2;
    logic [$clog2(`VLSU_NR_VREGS)-1:0] vd;
    logic [2:0]                        id;
  } vlsu_req_t;

  typedef struct packed {
    logic [2:0]                        id;
    logic [$clog2(`VLSU_NR_VREGS)-1:0] vd;
  } vlsu_rsp_t;

  typedef struct packed {
    rob_id_t                 id;
    logic [31:0]             addr;
    logic                    we;
    logic [`VLSU_ELENB-1:0]  strb;
    elen_t                   wdata;
    logic                    last;
  } mem_req_t;

  typedef struct packed {
    rob_id_t id;
    elen_t   rdata;
  } mem_result_t;

endpackage

// File: hdl/vlsu_issue.sv
`timescale 1ns/10ps

module vlsu_issue
  import vlsu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  vlsu_req_t req_i,
  input  logic      req_valid_i,
  input  logic      mem_done_i,
  input  logic      vrf_done_i,
  output logic      req_ready_o,
  output logic      start_o,
  output vlsu_req_t cur_req_o,
  output logic      rsp_valid_o,
  output vlsu_rsp_t rsp_o
);

  vlsu_req_t req_d;
  vlsu_req_t req_q;
  logic      busy;
  logic      finish;

  // A zero byte count means no instruction in flight
  assign busy   = req_q.vl != '0;
  assign finish = mem_done_i & vrf_done_i;

  assign req_ready_o = ~busy | finish;
  assign start_o     = req_valid_i & req_ready_o;

  // Single-cycle response once both sides have moved every byte
  assign rsp_valid_o = busy & finish;
  assign rsp_o.id    = req_q.id;
  assign rsp_o.vd    = req_q.vd;

  assign cur_req_o = req_q;

  always_comb begin
    req_d = req_q;
    if (start_o) begin
      req_d = req_i;
      // Element count to byte count
      case (req_i.vsew)
        EW_8:    req_d.vl = req_i.vl;
        EW_16:   req_d.vl = req_i.vl << 1;
        EW_32:   req_d.vl = req_i.vl << 2;
        default: req_d.vl = '0;
      endcase
    end else if (rsp_valid_o) begin
      req_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q <= '0;
    end else begin
      req_q <= req_d;
    end
  end

endmodule

// File: hdl/vlsu_addr_gen.sv
`timescale 1ns/10ps

`include "vlsu_params.svh"

module vlsu_addr_gen
  import vlsu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        start_i,
  input  vlsu_req_t   cur_req_i,
  input  logic        mem_adv_i,
  input  logic        vrf_adv_i,
  output logic [31:0] mem_addr_o,
  output logic [1:0]  mem_off_o,
  output logic [2:0]  mem_bytes_o,
  output logic        mem_active_o,
  output logic        mem_last_o,
  output vrf_addr_t   vrf_addr_o,
  output logic [1:0]  vrf_off_o,
  output logic [2:0]  vrf_bytes_o,
  output logic        vrf_active_o,
  output logic        mem_done_o,
  output logic        vrf_done_o
);

  typedef logic [`VLSU_VL_W-1:0] cnt_t;

  cnt_t        mem_cnt_q;
  cnt_t        vrf_cnt_q;
  cnt_t        mem_rem;
  cnt_t        vrf_rem;
  cnt_t        data_cnt;
  logic        is_load;
  logic        strided;
  logic [2:0]  step;
  logic [31:0] mem_byte_addr;
  logic [31:0] data_byte_addr;

  // Byte address of the element a counter points at
  function automatic logic [31:0] elem_addr(input vlsu_req_t req, input logic str,
                                            input cnt_t cnt);
    if (str) begin
      return req.rs1 + 32'(cnt >> req.vsew) * req.rs2;
    end
    return req.rs1 + 32'(cnt);
  endfunction

  // Bytes moved by the current beat, short on the tail
  function automatic logic [2:0] beat_len(input cnt_t rem, input logic [2:0] step_max);
    return (rem < cnt_t'(step_max)) ? rem[2:0] : step_max;
  endfunction

  assign is_load = (cur_req_i.op == VLE) || (cur_req_i.op == VLSE);
  assign strided = (cur_req_i.op == VLSE) || (cur_req_i.op == VSSE);

  // One element per beat when strided, else a whole word
  assign step = strided ? (3'd1 << cur_req_i.vsew) : 3'(`VLSU_ELENB);

  //////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////

  assign mem_rem      = cur_req_i.vl - mem_cnt_q;
  assign mem_active_o = mem_cnt_q < cur_req_i.vl;
  assign mem_done_o   = ~mem_active_o;
  assign mem_last_o   = mem_active_o & (mem_rem <= cnt_t'(step));
  assign mem_bytes_o  = beat_len(mem_rem, step);

  assign vrf_rem      = cur_req_i.vl - vrf_cnt_q;
  assign vrf_active_o = vrf_cnt_q < cur_req_i.vl;
  assign vrf_done_o   = ~vrf_active_o;
  assign vrf_bytes_o  = beat_len(vrf_rem, step);

  always_ff @(posedge clk_i) begin
    if (rst_i || start_i) begin
      mem_cnt_q <= '0;
      vrf_cnt_q <= '0;
    end else begin
      if (mem_adv_i) begin
        mem_cnt_q <= mem_cnt_q + cnt_t'(mem_bytes_o);
      end
      if (vrf_adv_i) begin
        vrf_cnt_q <= vrf_cnt_q + cnt_t'(vrf_bytes_o);
      end
    end
  end

  //////////////////////////////////////////////////
  // Addresses
  //////////////////////////////////////////////////

  assign mem_byte_addr = elem_addr(cur_req_i, strided, mem_cnt_q);
  assign mem_addr_o    = {mem_byte_addr[31:2], 2'b00};

  // Offsets follow the element that is currently in the data path,
  // the register side for loads and the memory side for stores
  assign data_cnt       = is_load ? vrf_cnt_q : mem_cnt_q;
  assign data_byte_addr = elem_addr(cur_req_i, strided, data_cnt);
  assign mem_off_o      = data_byte_addr[1:0];
  assign vrf_off_o      = data_cnt[1:0];

  assign vrf_addr_o = vrf_addr_t'(32'(cur_req_i.vd) * `VLSU_VREG_WORDS + 32'(vrf_cnt_q >> 2));

endmodule

// File: hdl/vlsu_rob.sv
`timescale 1ns/10ps

`include "vlsu_params.svh"

module vlsu_rob
  import vlsu_pkg::*;
#(
  parameter int unsigned NumWords = `VLSU_ROB_DEPTH
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    alloc_i,
  input  logic    push_i,
  input  rob_id_t push_id_i,
  input  elen_t   push_data_i,
  input  logic    pop_i,
  output rob_id_t alloc_id_o,
  output logic    head_valid_o,
  output elen_t   head_data_o,
  output rob_id_t head_id_o,
  output logic    full_o,
  output logic    empty_o
);

  localparam int unsigned IdW = $clog2(NumWords);

  typedef logic [IdW-1:0] ptr_t;

  elen_t               data_q [NumWords];
  logic [NumWords-1:0] written_q;
  ptr_t                alloc_ptr_q;
  ptr_t                head_ptr_q;
  logic [IdW:0]        count_q;
  ptr_t                push_ptr;

  assign push_ptr = ptr_t'(push_id_i);

  // IDs are handed out in order
  assign alloc_id_o = rob_id_t'(alloc_ptr_q);
  assign head_id_o  = rob_id_t'(head_ptr_q);

  // Head is released only once its own entry has been written
  assign head_valid_o = written_q[head_ptr_q];
  assign head_data_o  = data_q[head_ptr_q];

  assign full_o  = count_q == (IdW + 1)'(NumWords);
  assign empty_o = count_q == '0;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[push_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      written_q   <= '0;
      alloc_ptr_q <= '0;
      head_ptr_q  <= '0;
      count_q     <= '0;
    end else begin
      if (alloc_i) begin
        alloc_ptr_q <= alloc_ptr_q + 1'b1;
      end
      if (pop_i) begin
        head_ptr_q            <= head_ptr_q + 1'b1;
        written_q[head_ptr_q] <= 1'b0;
      end
      // Pushed entry never is the head being popped
      if (push_i) begin
        written_q[push_ptr] <= 1'b1;
      end
      case ({alloc_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: hdl/vlsu_datapath.sv
`timescale 1ns/10ps

`include "vlsu_params.svh"

module vlsu_datapath
  import vlsu_pkg::*;
(
  input  vlsu_req_t              cur_req_i,
  // Address generator
  input  logic [31:0]            mem_addr_i,
  input  logic [1:0]             mem_off_i,
  input  logic [2:0]             mem_bytes_i,
  input  logic                   mem_active_i,
  input  logic                   mem_last_i,
  input  vrf_addr_t              vrf_addr_i,
  input  logic [1:0]             vrf_off_i,
  input  logic [2:0]             vrf_bytes_i,
  input  logic                   vrf_active_i,
  // Reorder buffer status
  input  rob_id_t                rob_alloc_id_i,
  input  logic                   rob_head_valid_i,
  input  elen_t                  rob_head_data_i,
  input  rob_id_t                rob_head_id_i,
  input  logic                   rob_full_i,
  input  logic                   rob_empty_i,
  // Memory
  input  logic                   mem_ready_i,
  input  mem_result_t            mem_result_i,
  input  logic                   mem_result_valid_i,
  output logic                   mem_valid_o,
  output mem_req_t               mem_req_o,
  // Register file
  input  logic                   vrf_wvalid_i,
  input  elen_t                  vrf_rdata_i,
  input  logic                   vrf_rvalid_i,
  output logic                   vrf_we_o,
  output vrf_addr_t              vrf_waddr_o,
  output elen_t                  vrf_wdata_o,
  output logic [`VLSU_ELENB-1:0] vrf_wbe_o,
  output logic                   vrf_re_o,
  output vrf_addr_t              vrf_raddr_o,
  // Counter strobes and reorder buffer controls
  output logic                   mem_adv_o,
  output logic                   vrf_adv_o,
  output logic                   rob_alloc_o,
  output logic                   rob_push_o,
  output rob_id_t                rob_push_id_o,
  output elen_t                  rob_push_data_o,
  output logic                   rob_pop_o
);

  logic                   is_load;
  logic                   head_ok;
  logic [`VLSU_ELENB-1:0] byte_mask;

  // Rotate left by a number of bytes
  function automatic elen_t rot_bytes(input elen_t data, input logic [1:0] sh);
    case (sh)
      2'd1:    return {data[23:0], data[31:24]};
      2'd2:    return {data[15:0], data[31:16]};
      2'd3:    return {data[7:0], data[31:8]};
      default: return data;
    endcase
  endfunction

  // Enable for the lowest n bytes
  function automatic logic [`VLSU_ELENB-1:0] lead_mask(input logic [2:0] n);
    logic [`VLSU_ELENB-1:0] m;
    for (int k = 0; k < `VLSU_ELENB; k++) begin
      m[k] = k < int'(n);
    end
    return m;
  endfunction

  assign is_load = (cur_req_i.op == VLE) || (cur_req_i.op == VLSE);
  assign head_ok = rob_head_valid_i & ~rob_empty_i;

  // Strided beats carry one element, so the lead mask shifted to its offset
  // covers the element, while unit stride starts at offset zero
  assign byte_mask = is_load ? lead_mask(vrf_bytes_i) << vrf_off_i
                             : lead_mask(mem_bytes_i) << mem_off_i;

  // Register write moves the element from memory offset to register offset
  assign vrf_waddr_o = vrf_addr_i;
  assign vrf_wdata_o = rot_bytes(rob_head_data_i, vrf_off_i - mem_off_i);
  assign vrf_wbe_o   = byte_mask;
  assign vrf_raddr_o = vrf_addr_i;

  always_comb begin
    mem_valid_o     = 1'b0;
    mem_req_o       = '0;
    vrf_we_o        = 1'b0;
    vrf_re_o        = 1'b0;
    mem_adv_o       = 1'b0;
    vrf_adv_o       = 1'b0;
    rob_alloc_o     = 1'b0;
    rob_push_o      = 1'b0;
    rob_push_id_o   = '0;
    rob_push_data_o = '0;
    rob_pop_o       = 1'b0;

    mem_req_o.addr = mem_addr_i;
    mem_req_o.last = mem_last_i;

    if (is_load) begin
      //////////////////////////////////////////////////
      // Load: memory to buffer to register file
      //////////////////////////////////////////////////
      // Each request reserves the entry its result returns to
      mem_valid_o  = mem_active_i & ~rob_full_i;
      mem_req_o.id = rob_alloc_id_i;
      rob_alloc_o  = mem_valid_o & mem_ready_i;
      mem_adv_o    = rob_alloc_o;

      rob_push_o      = mem_result_valid_i;
      rob_push_id_o   = mem_result_i.id;
      rob_push_data_o = mem_result_i.rdata;

      // In-order write-back of the head
      vrf_we_o  = vrf_active_i & head_ok;
      rob_pop_o = vrf_we_o & vrf_wvalid_i;
      vrf_adv_o = rob_pop_o;
    end else begin
      //////////////////////////////////////////////////
      // Store: register file to buffer to memory
      //////////////////////////////////////////////////
      vrf_re_o        = vrf_active_i & ~rob_full_i;
      rob_alloc_o     = vrf_re_o & vrf_rvalid_i;
      rob_push_o      = rob_alloc_o;
      rob_push_id_o   = rob_alloc_id_i;
      rob_push_data_o = vrf_rdata_i;
      vrf_adv_o       = rob_alloc_o;

      mem_valid_o     = mem_active_i & head_ok;
      mem_req_o.id    = rob_head_id_i;
      mem_req_o.we    = 1'b1;
      mem_req_o.strb  = byte_mask;
      mem_req_o.wdata = rot_bytes(rob_head_data_i, mem_off_i - vrf_off_i);
      rob_pop_o       = mem_valid_o & mem_ready_i;
      mem_adv_o       = rob_pop_o;
    end
  end

endmodule

// File: hdl/vlsu_top.sv
`timescale 1ns/10ps

`include "vlsu_params.svh"

module vlsu_top
  import vlsu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Requester
  input  vlsu_req_t              req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  // Response
  output logic                   rsp_valid_o,
  output vlsu_rsp_t              rsp_o,
  // Memory
  output logic                   mem_valid_o,
  input  logic                   mem_ready_i,
  output mem_req_t               mem_req_o,
  input  logic                   mem_result_valid_i,
  input  mem_result_t            mem_result_i,
  // Register file write
  output logic                   vrf_we_o,
  output vrf_addr_t              vrf_waddr_o,
  output elen_t                  vrf_wdata_o,
  output logic [`VLSU_ELENB-1:0] vrf_wbe_o,
  input  logic                   vrf_wvalid_i,
  // Register file read
  output logic                   vrf_re_o,
  output vrf_addr_t              vrf_raddr_o,
  input  elen_t                  vrf_rdata_i,
  input  logic                   vrf_rvalid_i
);

  vlsu_req_t   cur_req;
  logic        start;
  logic        mem_done;
  logic        vrf_done;
  logic [31:0] mem_addr;
  logic [1:0]  mem_off;
  logic [2:0]  mem_bytes;
  logic        mem_active;
  logic        mem_last;
  vrf_addr_t   vrf_addr;
  logic [1:0]  vrf_off;
  logic [2:0]  vrf_bytes;
  logic        vrf_active;
  logic        mem_adv;
  logic        vrf_adv;
  logic        rob_alloc;
  logic        rob_push;
  rob_id_t     rob_push_id;
  elen_t       rob_push_data;
  logic        rob_pop;
  rob_id_t     rob_alloc_id;
  logic        rob_head_valid;
  elen_t       rob_head_data;
  rob_id_t     rob_head_id;
  logic        rob_full;
  logic        rob_empty;

  vlsu_issue i_issue (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .req_valid_i(req_valid_i),
    .mem_done_i (mem_done),
    .vrf_done_i (vrf_done),
    .req_ready_o(req_ready_o),
    .start_o    (start),
    .cur_req_o  (cur_req),
    .rsp_valid_o(rsp_valid_o),
    .rsp_o      (rsp_o)
  );

  vlsu_addr_gen i_addr_gen (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (start),
    .cur_req_i   (cur_req),
    .mem_adv_i   (mem_adv),
    .vrf_adv_i   (vrf_adv),
    .mem_addr_o  (mem_addr),
    .mem_off_o   (mem_off),
    .mem_bytes_o (mem_bytes),
    .mem_active_o(mem_active),
    .mem_last_o  (mem_last),
    .vrf_addr_o  (vrf_addr),
    .vrf_off_o   (vrf_off),
    .vrf_bytes_o (vrf_bytes),
    .vrf_active_o(vrf_active),
    .mem_done_o  (mem_done),
    .vrf_done_o  (vrf_done)
  );

  vlsu_rob #(
    .NumWords(`VLSU_ROB_DEPTH)
  ) i_rob (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .alloc_i     (rob_alloc),
    .push_i      (rob_push),
    .push_id_i   (rob_push_id),
    .push_data_i (rob_push_data),
    .pop_i       (rob_pop),
    .alloc_id_o  (rob_alloc_id),
    .head_valid_o(rob_head_valid),
    .head_data_o (rob_head_data),
    .head_id_o   (rob_head_id),
    .full_o      (rob_full),
    .empty_o     (rob_empty)
  );

  vlsu_datapath i_datapath (
    .cur_req_i         (cur_req),
    .mem_addr_i        (mem_addr),
    .mem_off_i         (mem_off),
    .mem_bytes_i       (mem_bytes),
    .mem_active_i      (mem_active),
    .mem_last_i        (mem_last),
    .vrf_addr_i        (vrf_addr),
    .vrf_off_i         (vrf_off),
    .vrf_bytes_i       (vrf_bytes),
    .vrf_active_i      (vrf_active),
    .rob_alloc_id_i    (rob_alloc_id),
    .rob_head_valid_i  (rob_head_valid),
    .rob_head_data_i   (rob_head_data),
    .rob_head_id_i     (rob_head_id),
    .rob_full_i        (rob_full),
    .rob_empty_i       (rob_empty),
    .mem_ready_i       (mem_ready_i),
    .mem_result_i      (mem_result_i),
    .mem_result_valid_i(mem_result_valid_i),
    .mem_valid_o       (mem_valid_o),
    .mem_req_o         (mem_req_o),
    .vrf_wvalid_i      (vrf_wvalid_i),
    .vrf_rdata_i       (vrf_rdata_i),
    .vrf_rvalid_i      (vrf_rvalid_i),
    .vrf_we_o          (vrf_we_o),
    .vrf_waddr_o       (vrf_waddr_o),
    .vrf_wdata_o       (vrf_wdata_o),
    .vrf_wbe_o         (vrf_wbe_o),
    .vrf_re_o          (vrf_re_o),
    .vrf_raddr_o       (vrf_raddr_o),
    .mem_adv_o         (mem_adv),
    .vrf_adv_o         (vrf_adv),
    .rob_alloc_o       (rob_alloc),
    .rob_push_o        (rob_push),
    .rob_push_id_o     (rob_push_id),
    .rob_push_data_o   (rob_push_data),
    .rob_pop_o         (rob_pop)
  );

endmodule

// File: bench/vlsu_tb.sv
`timescale 1ns/10ps

module vlsu_tb
  import vlsu_pkg::*;
();

  localparam int MEM_WORDS = 512;
  localparam int VRF_WORDS = 256;
  localparam int TRACE_WORDS = 256;
  localparam int WAIT_LIMIT = 4000;

  logic        clk_i;
  logic        rst_i;
  vlsu_req_t   req_i;
  logic        req_valid_i;
  logic        req_ready_o;
  logic        rsp_valid_o;
  vlsu_rsp_t   rsp_o;
  logic        mem_valid_o;
  logic        mem_ready_i;
  mem_req_t    mem_req_o;
  logic        mem_result_valid_i;
  mem_result_t mem_result_i;
  logic        vrf_we_o;
  vrf_addr_t   vrf_waddr_o;
  elen_t       vrf_wdata_o;
  logic [3:0]  vrf_wbe_o;
  logic        vrf_wvalid_i;
  logic        vrf_re_o;
  vrf_addr_t   vrf_raddr_o;
  elen_t       vrf_rdata_i;
  logic        vrf_rvalid_i;

  logic [31:0] trace [TRACE_WORDS];
  logic [31:0] mem_words [MEM_WORDS];
  logic [31:0] mem_exp [MEM_WORDS];
  logic [31:0] vrf_words [VRF_WORDS];
  logic [31:0] vrf_exp [VRF_WORDS];
  mem_result_t pending [$];

  int errors;
  int tests_passed;
  int tests_failed;
  int accept_count;
  int rsp_count;
  int protocol_errs;
  int beat_count;
  int exp_beats;
  bit in_flight;
  bit aborted;

  vlsu_top UUT (.*);

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  // Ends stimulus early, the closing report follows in the main sequence
  task automatic flag_abort(input string msg);
    $display("%s", msg);
    aborted = 1'b1;
  endtask

  function automatic string test_name(input int num);
    case (num)
      1:       return "reset state";
      2:       return "unit-stride 32-bit load";
      3:       return "unit-stride 8-bit store";
      4:       return "strided 16-bit load";
      5:       return "strided 8-bit store";
      default: return "one response per request";
    endcase
  endfunction

  task automatic end_test(input int num, input int err_before);
    if (errors == err_before) begin
      tests_passed++;
      $display("test %0d (%s): pass", num, test_name(num));
    end else begin
      tests_failed++;
      $display("test %0d (%s): fail", num, test_name(num));
    end
  endtask

  // Whole memory and register file against the expected images
  task automatic compare_images();
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_value(mem_words[i], mem_exp[i], $sformatf("memory word at %h", i * 4));
    end
    for (int i = 0; i < VRF_WORDS; i++) begin
      check_value(vrf_words[i], vrf_exp[i], $sformatf("register word %0d", i));
    end
  endtask

  task automatic run_instr(input logic [31:0] ctrl, input logic [31:0] base,
                           input logic [31:0] stride);
    int waited;
    int nbytes;
    vlsu_rsp_t got;

    // One beat per element when strided, one per started word otherwise
    nbytes = int'(ctrl[21:16]) << ctrl[25:24];
    if (ctrl[29]) begin
      exp_beats = int'(ctrl[21:16]);
    end else begin
      exp_beats = (nbytes + 3) / 4;
    end
    beat_count = 0;

    @(posedge clk_i);
    req_i.op    <= vlsu_op_e'(ctrl[29:28]);
    req_i.vsew  <= vsew_e'(ctrl[25:24]);
    req_i.vl    <= ctrl[21:16];
    req_i.vd    <= ctrl[12:8];
    req_i.id    <= ctrl[2:0];
    req_i.rs1   <= base;
    req_i.rs2   <= stride;
    req_valid_i <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!req_ready_o && waited < WAIT_LIMIT);
    req_valid_i <= 1'b0;
    if (!req_ready_o) begin
      flag_abort("timeout: request was never accepted");
    end else begin
      waited = 0;
      do begin
        @(posedge clk_i);
        waited++;
      end while (!rsp_valid_o && waited < WAIT_LIMIT);
      if (!rsp_valid_o) begin
        flag_abort("timeout: no response after the request");
      end else begin
        got = rsp_o;
        check_value(32'(got.id), 32'(ctrl[2:0]), "response id");
        check_value(32'(got.vd), 32'(ctrl[12:8]), "response vd");
        check_value(32'(beat_count), 32'(exp_beats), "memory beats issued");
      end
    end
  endtask

  ////////////////////////////////////////////////////
  // Memory and register file models
  ////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    int idx;
    mem_result_t res;

    if (mem_valid_o && mem_ready_i) begin
      idx = int'(mem_req_o.addr[10:2]);
      check_value(32'(mem_req_o.last), 32'(beat_count == exp_beats - 1),
                  "last flag of a memory beat");
      beat_count++;
      if (mem_req_o.we) begin
        for (int k = 0; k < 4; k++) begin
          if (mem_req_o.strb[k]) mem_words[idx][8*k +: 8] = mem_req_o.wdata[8*k +: 8];
        end
      end else begin
        res.id    = mem_req_o.id;
        res.rdata = mem_words[idx];
        pending.push_back(res);
      end
    end
    mem_ready_i <= ($urandom % 3) != 0;
    // Results go back in random order
    if (pending.size() > 0 && ($urandom % 2) == 1) begin
      idx = int'($urandom % pending.size());
      mem_result_i       <= pending[idx];
      mem_result_valid_i <= 1'b1;
      pending.delete(idx);
    end else begin
      mem_result_valid_i <= 1'b0;
    end
  end

  always @(posedge clk_i) begin
    if (vrf_we_o && vrf_wvalid_i) begin
      for (int k = 0; k < 4; k++) begin
        if (vrf_wbe_o[k]) vrf_words[vrf_waddr_o][8*k +: 8] = vrf_wdata_o[8*k +: 8];
      end
    end
    vrf_wvalid_i <= ($urandom % 2) == 1;
    // Read address only moves on a completed read, so data stays matched
    vrf_rvalid_i <= vrf_re_o && !vrf_rvalid_i && (($urandom % 2) == 1);
    vrf_rdata_i  <= vrf_words[vrf_raddr_o];
  end

  // Response pulse and ready monitor
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (rsp_valid_o) begin
        if (!in_flight) protocol_errs++;
        rsp_count++;
        in_flight = 1'b0;
      end else if (in_flight && req_ready_o) begin
        protocol_errs++;
      end
      if (req_valid_i && req_ready_o) begin
        accept_count++;
        in_flight = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////

  initial begin
    int pos;
    int err_before;

    void'($urandom(32'h5c76798a));
    clk_i = 1'b0;
    rst_i = 1'b1;
    req_i = '0;
    req_valid_i = 1'b0;
    mem_ready_i = 1'b0;
    mem_result_valid_i = 1'b0;
    mem_result_i = '0;
    vrf_wvalid_i = 1'b0;
    vrf_rdata_i = '0;
    vrf_rvalid_i = 1'b0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    accept_count = 0;
    rsp_count = 0;
    protocol_errs = 0;
    beat_count = 0;
    exp_beats = 0;
    in_flight = 1'b0;
    aborted = 1'b0;
    for (int i = 0; i < TRACE_WORDS; i++) trace[i] = '0;
    // Background fill depends on the full word address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_words[i] = (32'(i) * 32'h01000193) ^ 32'hc3a5_0f1e;
      mem_exp[i]   = mem_words[i];
    end
    for (int i = 0; i < VRF_WORDS; i++) begin
      vrf_words[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
      vrf_exp[i]   = vrf_words[i];
    end
    $readmemh("bench/vlsu_trace.txt", trace);

    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    @(posedge clk_i);
    err_before = errors;
    check_value(32'(req_ready_o), 32'd1, "req_ready_o after reset");
    check_value(32'(rsp_valid_o), 32'd0, "rsp_valid_o after reset");
    check_value(32'(mem_valid_o), 32'd0, "mem_valid_o after reset");
    check_value(32'(vrf_we_o), 32'd0, "vrf_we_o after reset");
    check_value(32'(vrf_re_o), 32'd0, "vrf_re_o after reset");
    end_test(1, err_before);

    // Records of four words: kind and three arguments
    err_before = errors;
    pos = 0;
    while (!aborted && pos + 3 < TRACE_WORDS && trace[pos] != 0) begin
      case (trace[pos])
        1: begin
          mem_words[trace[pos+1][10:2]] = trace[pos+2];
          mem_exp[trace[pos+1][10:2]]   = trace[pos+2];
        end
        2: begin
          vrf_words[trace[pos+1][7:0]] = trace[pos+2];
          vrf_exp[trace[pos+1][7:0]]   = trace[pos+2];
        end
        3: run_instr(trace[pos+1], trace[pos+2], trace[pos+3]);
        4: mem_exp[trace[pos+1][10:2]] = trace[pos+2];
        5: vrf_exp[trace[pos+1][7:0]] = trace[pos+2];
        6: begin
          compare_images();
          end_test(int'(trace[pos+1]), err_before);
          err_before = errors;
        end
        default: flag_abort("trace file holds an unknown record kind");
      endcase
      pos += 4;
    end

    if (!aborted) begin
      repeat (4) @(posedge clk_i);
      err_before = errors;
      check_value(32'(rsp_count), 32'(accept_count), "responses against accepted requests");
      check_value(32'(accept_count), 32'd4, "accepted requests");
      check_value(32'(protocol_errs), 32'd0, "extra pulses or early ready");
      end_test(6, err_before);
    end

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (!aborted && errors == 0 && tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: bench/vlsu_trace.txt
// kind a b c: 1 mem preload (addr data), 2 reg preload (word data), 3 instr (ctrl rs1 rs2)
// 4 expect mem (addr data), 5 expect reg (word data), 6 end of test (number); ctrl op ew vl vd id
1 100 10203040 0  1 104 11213141 0  1 108 12223242 0  1 10c 13233343 0
1 110 14243444 0  1 114 15253545 0  1 118 16263646 0  1 11c 17273747 0
3 02080205 100 0
5 10 10203040 0  5 11 11213141 0  5 12 12223242 0  5 13 13233343 0
5 14 14243444 0  5 15 15253545 0  5 16 16263646 0  5 17 17273747 0
6 2 0 0
2 18 44332211 0  2 19 88776655 0  1 200 aaaaaaaa 0  1 204 bbbbbbbb 0
3 10060306 200 0
4 200 44332211 0  4 204 bbbb6655 0
6 3 0 0
1 300 22221111 0  1 304 44443333 0  1 308 66665555 0  1 30c 88887777 0
1 310 aaaa9999 0
3 21040401 300 6
5 20 44441111 0  5 21 aaaa7777 0
6 4 0 0
2 28 ddccbbaa 0  1 400 11111111 0  1 404 22222222 0  1 408 33333333 0
1 40c 44444444 0
3 30040502 400 5
4 400 111111aa 0  4 404 2222bb22 0  4 408 33cc3333 0  4 40c dd444444 0
6 5 0 0

// File: list.f
+incdir+hdl
hdl/vlsu_pkg.sv
hdl/vlsu_issue.sv
hdl/vlsu_addr_gen.sv
hdl/vlsu_rob.sv
hdl/vlsu_datapath.sv
hdl/vlsu_top.sv
bench/vlsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= vlsu_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build outputs"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
